//--- rtl/CorePackage.sv
package CorePackage;

	// Architectural sizes
	localparam int registerCount = 32; // 16 selects the RV32E register file
	localparam int xlen = 32;

	// Major opcodes handled by this pipeline
	typedef enum logic [6:0]
	{
		opOp = 7'b0110011, // Register-register ALU
		opOpImm = 7'b0010011, // Register-immediate ALU
		opLui = 7'b0110111
	} Opcode_t;

	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} AluOperation_t;

	typedef struct packed
	{
		logic [4:0] rs1Address;
		logic [4:0] rs2Address;
		logic [4:0] rdAddress;
	} DecodedAddresses_t;

	// Output of the decode stage
	typedef struct packed
	{
		logic valid;
		DecodedAddresses_t addresses;
		AluOperation_t operation;
		logic useImmediate; // operandB comes from immediate
		logic [xlen-1:0] immediate;
		logic writesRd; // Never set for rd zero
	} DecodedInstruction_t;

	// Output of the operand stage
	typedef struct packed
	{
		logic valid;
		logic writesRd;
		logic [4:0] rdAddress;
		AluOperation_t operation;
		logic [xlen-1:0] operandA;
		logic [xlen-1:0] operandB;
	} OperandBundle_t;

	// Result travelling to the register file and the bypass network
	typedef struct packed
	{
		logic writeEnable;
		logic [4:0] rdAddress;
		logic [xlen-1:0] value;
	} WriteBack_t;

endpackage

//--- rtl/ExecuteStage.sv
module ExecuteStage
(
	input logic clock,
	input logic reset,
	input CorePackage::OperandBundle_t operands,
	output CorePackage::WriteBack_t nearForward,
	output CorePackage::WriteBack_t writeBack
);

	logic [CorePackage::xlen-1:0] operandA;
	logic [CorePackage::xlen-1:0] operandB;
	logic [4:0] shiftAmount;
	logic [CorePackage::xlen-1:0] result;

	assign operandA = operands.operandA;
	assign operandB = operands.operandB;
	assign shiftAmount = operandB[4:0]; // Low five bits only

	always_comb
	begin
		case (operands.operation)
			CorePackage::aluAdd:
				result = operandA + operandB;
			CorePackage::aluSub:
				result = operandA - operandB;
			CorePackage::aluSll:
				result = operandA << shiftAmount;
			CorePackage::aluSlt:
				result = {{(CorePackage::xlen - 1){1'b0}}, $signed(operandA) < $signed(operandB)};
			CorePackage::aluSltu:
				result = {{(CorePackage::xlen - 1){1'b0}}, operandA < operandB};
			CorePackage::aluXor:
				result = operandA ^ operandB;
			CorePackage::aluSrl:
				result = operandA >> shiftAmount;
			CorePackage::aluSra:
				result = $signed(operandA) >>> shiftAmount; // Sign fill
			CorePackage::aluOr:
				result = operandA | operandB;
			CorePackage::aluAnd:
				result = operandA & operandB;
			default:
				result = '0;
		endcase
	end

	// Same-cycle result for the instruction now in operand fetch
	always_comb
	begin
		nearForward.writeEnable = operands.valid && operands.writesRd;
		nearForward.rdAddress = operands.rdAddress;
		nearForward.value = result;
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
			writeBack <= '0;
		else
			writeBack <= nearForward;
	end

endmodule

//--- rtl/InstructionDecoder.sv
module InstructionDecoder
(
	input logic clock,
	input logic reset,
	input logic [31:0] instruction,
	input logic instructionValid,
	output CorePackage::DecodedInstruction_t decoded,
	output logic illegalInstruction
);

	CorePackage::Opcode_t opcode;
	CorePackage::DecodedAddresses_t fields;
	CorePackage::DecodedInstruction_t nextDecoded;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal;

	assign opcode = CorePackage::Opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign fields.rs1Address = instruction[19:15];
	assign fields.rs2Address = instruction[24:20];
	assign fields.rdAddress = instruction[11:7];

	// Register field must name an implemented register
	function automatic logic inRange(input logic [4:0] address);
		return int'(address) < CorePackage::registerCount;
	endfunction

	function automatic CorePackage::AluOperation_t mapOperation(input logic [2:0] code,
		input logic alternate);
		case (code)
			3'b000: return alternate ? CorePackage::aluSub : CorePackage::aluAdd;
			3'b001: return CorePackage::aluSll;
			3'b010: return CorePackage::aluSlt;
			3'b011: return CorePackage::aluSltu;
			3'b100: return CorePackage::aluXor;
			3'b101: return alternate ? CorePackage::aluSra : CorePackage::aluSrl;
			3'b110: return CorePackage::aluOr;
			default: return CorePackage::aluAnd;
		endcase
	endfunction

	always_comb
	begin
		nextDecoded = '0;
		nextDecoded.addresses = fields;
		legal = 1'b0;
		case (opcode)
			CorePackage::opOp:
			begin
				legal = funct7 == 7'b0000000
					|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				legal = legal && inRange(fields.rs1Address) && inRange(fields.rs2Address)
					&& inRange(fields.rdAddress);
				nextDecoded.operation = mapOperation(funct3, funct7[5]);
			end
			CorePackage::opOpImm:
			begin
				if (funct3 == 3'b001) // SLLI
					legal = funct7 == 7'b0000000;
				else if (funct3 == 3'b101) // SRLI or SRAI
					legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
				else
					legal = 1'b1;
				legal = legal && inRange(fields.rs1Address) && inRange(fields.rdAddress);
				nextDecoded.operation = mapOperation(funct3, funct3 == 3'b101 && funct7[5]);
				nextDecoded.useImmediate = 1'b1;
				nextDecoded.immediate = {{20{instruction[31]}}, instruction[31:20]}; // I-type
			end
			CorePackage::opLui:
			begin
				legal = inRange(fields.rdAddress);
				nextDecoded.addresses.rs1Address = 5'd0; // x0 plus immediate
				nextDecoded.operation = CorePackage::aluAdd;
				nextDecoded.useImmediate = 1'b1;
				nextDecoded.immediate = {instruction[31:12], 12'h000}; // U-type
			end
			default:
				legal = 1'b0;
		endcase
		nextDecoded.valid = instructionValid && legal;
		nextDecoded.writesRd = legal && fields.rdAddress != 5'd0;
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			decoded <= '0;
			illegalInstruction <= 1'b0;
		end
		else
		begin
			decoded <= nextDecoded;
			illegalInstruction <= instructionValid && !legal; // One pulse per bad encoding
		end
	end

endmodule

//--- rtl/IntegerPipeline.sv
module IntegerPipeline
(
	input logic clock,
	input logic reset,
	input logic [31:0] instruction,
	input logic instructionValid,
	output logic retireValid,
	output logic [4:0] retireRd,
	output logic [31:0] retireValue,
	output logic illegalInstruction,
	output logic [31:0] x31
);

	CorePackage::DecodedInstruction_t decoded;
	CorePackage::OperandBundle_t operands;
	CorePackage::WriteBack_t nearForward;
	CorePackage::WriteBack_t writeBack;
	logic [31:0] rs1;
	logic [31:0] rs2;

	InstructionDecoder InstructionDecoder_inst
	(
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.instructionValid(instructionValid),
		.decoded(decoded),
		.illegalInstruction(illegalInstruction)
	);

	RegisterFile #(.numberOfRegisters(CorePackage::registerCount)) RegisterFile_inst
	(
		.clock(clock),
		.reset(reset),
		.decodedAddresses(decoded.addresses),
		.rs1(rs1),
		.rs2(rs2),
		.x31(x31),
		.writeBack(writeBack)
	);

	OperandStage OperandStage_inst
	(
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.rs1(rs1),
		.rs2(rs2),
		.nearForward(nearForward),
		.farForward(writeBack), // Registered result doubles as far bypass
		.operands(operands)
	);

	ExecuteStage ExecuteStage_inst
	(
		.clock(clock),
		.reset(reset),
		.operands(operands),
		.nearForward(nearForward),
		.writeBack(writeBack)
	);

	assign retireValid = writeBack.writeEnable;
	assign retireRd = writeBack.rdAddress;
	assign retireValue = writeBack.value;

endmodule

//--- rtl/OperandStage.sv
module OperandStage
(
	input logic clock,
	input logic reset,
	input CorePackage::DecodedInstruction_t decoded,
	input logic [31:0] rs1,
	input logic [31:0] rs2,
	input CorePackage::WriteBack_t nearForward,
	input CorePackage::WriteBack_t farForward,
	output CorePackage::OperandBundle_t operands
);

	CorePackage::OperandBundle_t nextOperands;
	logic [CorePackage::xlen-1:0] sourceA;
	logic [CorePackage::xlen-1:0] sourceB;

	// Newest producer wins
	function automatic logic [CorePackage::xlen-1:0] resolve(input logic [4:0] address,
		input logic [CorePackage::xlen-1:0] fileValue);
		if (nearForward.writeEnable && nearForward.rdAddress == address)
			return nearForward.value; // Result one instruction ahead
		if (farForward.writeEnable && farForward.rdAddress == address)
			return farForward.value; // Result two instructions ahead
		return fileValue;
	endfunction

	assign sourceA = resolve(decoded.addresses.rs1Address, rs1);
	assign sourceB = resolve(decoded.addresses.rs2Address, rs2);

	always_comb
	begin
		nextOperands.valid = decoded.valid;
		nextOperands.writesRd = decoded.writesRd;
		nextOperands.rdAddress = decoded.addresses.rdAddress;
		nextOperands.operation = decoded.operation;
		nextOperands.operandA = sourceA;
		nextOperands.operandB = decoded.useImmediate ? decoded.immediate : sourceB;
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
			operands <= '0;
		else
			operands <= nextOperands;
	end

endmodule

//--- rtl/RegisterFile.sv
module RegisterFile
#(
	parameter int numberOfRegisters = 32
)
(
	input logic clock,
	input logic reset,
	input CorePackage::DecodedAddresses_t decodedAddresses,
	output logic [31:0] rs1,
	output logic [31:0] rs2,
	output logic [31:0] x31,
	input CorePackage::WriteBack_t writeBack
);

	// x0 has no storage
	logic [CorePackage::xlen-1:0] registers [numberOfRegisters-1:1];

	function automatic logic [CorePackage::xlen-1:0] readRegister(input logic [4:0] address);
		if (address == 5'd0 || int'(address) >= numberOfRegisters)
			return '0; // x0 and absent registers
		return registers[address];
	endfunction

	assign rs1 = readRegister(decodedAddresses.rs1Address);
	assign rs2 = readRegister(decodedAddresses.rs2Address);

	generate
		if (numberOfRegisters == 32)
		begin : fullFile
			assign x31 = registers[31];
		end
		else
		begin : embeddedFile
			assign x31 = 'x; // No x31 in RV32E
		end
	endgenerate

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < numberOfRegisters; i++)
				registers[i] <= '0;
		end
		else if (writeBack.writeEnable && writeBack.rdAddress != 5'd0
			&& int'(writeBack.rdAddress) < numberOfRegisters)
		begin
			registers[writeBack.rdAddress] <= writeBack.value;
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the integer pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module IntegerPipelineTb -f verilog.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

output=$(./obj_dir/VIntegerPipelineTb 2>&1)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "All tests passed" <<< "$output"; then
	exit 0
fi
exit 1

//--- verification/IntegerPipelineChk.sv
module IntegerPipelineChk
(
	input logic clock,
	input logic reset,
	input logic retireValid,
	input logic [4:0] retireRd,
	input logic illegalInstruction
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [1:0] cyclesSinceReset;

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
			cyclesSinceReset <= 2'd0;
		else if (cyclesSinceReset != 2'd3)
			cyclesSinceReset <= cyclesSinceReset + 2'd1; // Saturates at three
	end

	retireNeverX0: assert property (@(posedge clock) disable iff (reset)
		retireValid |-> retireRd != 5'd0)
		else $error("Retire reported for x0");

	quietAfterReset: assert property (@(posedge clock)
		cyclesSinceReset != 2'd3 |-> !retireValid)
		else $error("Retire within three cycles of reset release");

	noIllegalInReset: assert property (@(posedge clock) reset |-> !illegalInstruction)
		else $error("Illegal instruction flagged during reset");

endmodule

bind IntegerPipeline IntegerPipelineChk IntegerPipelineChk_inst
(
	.clock(clock),
	.reset(reset),
	.retireValid(retireValid),
	.retireRd(retireRd),
	.illegalInstruction(illegalInstruction)
);

//--- verification/IntegerPipelineTb.sv
module IntegerPipelineTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 8;
	localparam int randomCount = 400;
	localparam int watchdogCycles = resetCycles + randomCount * 2 + 50;

	typedef struct packed
	{
		logic [4:0] rd;
		logic [31:0] value;
		logic [31:0] dueEdge; // Edge that writes the register file
	} RetireEntry_t;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] instruction;
	logic instructionValid;
	logic retireValid;
	logic [4:0] retireRd;
	logic [31:0] retireValue;
	logic illegalInstruction;
	logic [31:0] x31;

	logic [31:0] lcgState;
	logic [31:0] cycleCount = '0;
	logic [31:0] modelRegs [32];
	RetireEntry_t expectedQueue[$];
	string nameQueue[$];
	RetireEntry_t pending;
	string pendingName;
	int expectedIllegal = 0;
	int illegalSeen = 0;
	int mismatchCount = 0;
	int unexpectedCount = 0;
	int otherCount = 0;
	int sent;

	IntegerPipeline IntegerPipeline_inst
	(
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.instructionValid(instructionValid),
		.retireValid(retireValid),
		.retireRd(retireRd),
		.retireValue(retireValue),
		.illegalInstruction(illegalInstruction),
		.x31(x31)
	);

	always #10 clock = ~clock;

	always @(posedge clock)
		cycleCount <= cycleCount + 32'd1;

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] encodeRegister(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encodeImmediate(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd);
		return {imm, rs1, funct3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] encodeUpper(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	// Mostly x1 to x4 and x31 so that dependencies pile up
	function automatic logic [4:0] pickRegister();
		logic [31:0] r;
		logic [31:0] s;
		r = nextRandom();
		s = nextRandom();
		if ((r >> 16) % 32'd10 >= 32'd6)
			return s[27:23];
		case ((r >> 8) % 32'd5)
			0: return 5'd1;
			1: return 5'd2;
			2: return 5'd3;
			3: return 5'd4;
			default: return 5'd31;
		endcase
	endfunction

	function automatic logic [31:0] randomInstruction();
		logic [31:0] kind;
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		kind = (nextRandom() >> 16) % 32'd100;
		rd = pickRegister();
		rs1 = pickRegister();
		rs2 = pickRegister();
		r = nextRandom();
		f3 = r[18:16];
		imm = r[31:20];
		if (kind < 45)
		begin
			if ((f3 == 3'b000 || f3 == 3'b101) && r[9]) // SUB or SRA
				return encodeRegister(7'b0100000, rs2, rs1, f3, rd);
			return encodeRegister(7'b0000000, rs2, rs1, f3, rd);
		end
		if (kind < 80)
		begin
			if (f3 == 3'b001)
				return encodeImmediate({7'b0000000, imm[4:0]}, rs1, f3, rd);
			if (f3 == 3'b101)
				return encodeImmediate({1'b0, r[9], 5'b00000, imm[4:0]}, rs1, f3, rd);
			return encodeImmediate(imm, rs1, f3, rd);
		end
		if (kind < 92)
			return encodeUpper(r[31:12], rd);
		case ((nextRandom() >> 16) % 32'd4)
			0: return {r[31:7], 7'b1100011}; // Branch opcode
			1: return encodeRegister(7'b0000001, rs2, rs1, f3, rd); // M extension
			2: return encodeRegister(7'b0100000, rs2, rs1, 3'b100, rd);
			default: return encodeImmediate({7'b0100000, imm[4:0]}, rs1, 3'b001, rd);
		endcase
	endfunction

	function automatic logic [31:0] referenceAlu(input logic [2:0] funct3, input logic alternate,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] signedA;
		logic signed [31:0] signedB;
		logic [31:0] shifted;
		signedA = a;
		signedB = b;
		shifted = signedA >>> b[4:0];
		case (funct3)
			3'b000: return alternate ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return signedA < signedB ? 32'd1 : 32'd0;
			3'b011: return a < b ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alternate ? shifted : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Drives one instruction and runs it through the in-order model
	task automatic issue(input logic [31:0] word, input string testName);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rd;
		logic [31:0] operandA;
		logic [31:0] operandB;
		logic alternate;
		logic legal;
		RetireEntry_t entry;
		@(posedge clock);
		#2;
		instruction = word;
		instructionValid = 1'b1;
		f3 = word[14:12];
		f7 = word[31:25];
		rd = word[11:7];
		operandA = modelRegs[word[19:15]];
		operandB = modelRegs[word[24:20]];
		alternate = 1'b0;
		case (word[6:0])
			7'b0110011:
			begin
				legal = f7 == 7'b0000000 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
				alternate = f7[5];
			end
			7'b0010011:
			begin
				operandB = {{20{word[31]}}, word[31:20]};
				if (f3 == 3'b001)
					legal = f7 == 7'b0000000;
				else if (f3 == 3'b101)
					legal = f7 == 7'b0000000 || f7 == 7'b0100000;
				else
					legal = 1'b1;
				alternate = f3 == 3'b101 && f7[5];
			end
			7'b0110111:
			begin
				legal = 1'b1;
				f3 = 3'b000;
				operandA = '0;
				operandB = {word[31:12], 12'h000};
			end
			default:
				legal = 1'b0;
		endcase
		if (!legal)
			expectedIllegal++;
		else if (rd != 5'd0)
		begin
			modelRegs[rd] = referenceAlu(f3, alternate, operandA, operandB);
			entry.rd = rd;
			entry.value = modelRegs[rd];
			entry.dueEdge = cycleCount + 32'd4; // Sampled at the next edge, written three later
			expectedQueue.push_back(entry);
			nameQueue.push_back(testName);
		end
	endtask

	task automatic idle();
		@(posedge clock);
		#2;
		instructionValid = 1'b0;
		instruction = nextRandom(); // Junk that must be ignored
	endtask

	always @(negedge clock)
	begin
		if (!reset && illegalInstruction)
			illegalSeen++;
		if (!reset && retireValid)
		begin
			if (expectedQueue.size() == 0)
			begin
				unexpectedCount++;
				$display("Unexpected retire of x%0d with value %h while nothing was pending",
					retireRd, retireValue);
			end
			else
			begin
				pending = expectedQueue.pop_front();
				pendingName = nameQueue.pop_front();
				if (retireRd != pending.rd)
				begin
					mismatchCount++;
					$display("mismatch %s rd expected %0d actual %0d", pendingName, pending.rd,
						retireRd);
				end
				if (retireValue !== pending.value)
				begin
					mismatchCount++;
					$display("mismatch %s value expected %h actual %h", pendingName, pending.value,
						retireValue);
				end
				if (cycleCount + 32'd1 != pending.dueEdge)
				begin
					otherCount++;
					$display("Retire of x%0d in %s ended at edge %0d but edge %0d was due", retireRd,
						pendingName, cycleCount + 32'd1, pending.dueEdge);
				end
			end
		end
	end

	initial
	begin
		#(watchdogCycles * 20);
		$display("Timeout after %0d cycles with the pipeline still running", watchdogCycles);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		lcgState = 32'hfcea_16a5;
		reset = 1'b1;
		instruction = '0; // Opcode zero is an illegal encoding
		instructionValid = 1'b1; // Offered while reset holds the decoder
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		repeat (resetCycles) @(posedge clock);
		#2;
		reset = 1'b0;
		instructionValid = 1'b0;
		if (x31 !== 32'd0)
		begin
			mismatchCount++;
			$display("mismatch reset x31 expected %h actual %h", 32'd0, x31);
		end
		issue(encodeImmediate(12'd7, 5'd1, 3'b000, 5'd5), "prologue"); // x1 still zero
		repeat (4) idle();
		issue(encodeRegister(7'b0000000, 5'd3, 5'd2, 3'b110, 5'd6), "prologue");
		repeat (4) idle();
		issue(encodeUpper(20'hdead0, 5'd1), "dependency");
		issue(encodeImmediate(12'h7ff, 5'd1, 3'b000, 5'd2), "dependency"); // Near bypass
		issue(encodeRegister(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3), "dependency"); // Near and far
		issue(encodeRegister(7'b0100000, 5'd3, 5'd1, 3'b101, 5'd4), "dependency"); // x1 from file
		issue(encodeImmediate(12'd99, 5'd0, 3'b000, 5'd0), "x0Write");
		issue(encodeRegister(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd7), "x0Write");
		issue(encodeImmediate(12'd1, 5'd0, 3'b100, 5'd8), "x0Write");
		sent = 0;
		while (sent < randomCount)
		begin
			if ((nextRandom() >> 16) % 32'd4 != 32'd0)
			begin
				issue(randomInstruction(), "random");
				sent++;
			end
			else
				idle();
		end
		repeat (10) idle();
		if (expectedQueue.size() != 0)
		begin
			otherCount++;
			$display("%0d expected retires never arrived", expectedQueue.size());
		end
		if (illegalSeen != expectedIllegal)
		begin
			mismatchCount++;
			$display("mismatch illegalCount expected %0d actual %0d", expectedIllegal, illegalSeen);
		end
		if (x31 !== modelRegs[31])
		begin
			mismatchCount++;
			$display("mismatch finalX31 expected %h actual %h", modelRegs[31], x31);
		end
		$display("Errors: mismatches %0d, unexpected retires %0d, other %0d", mismatchCount,
			unexpectedCount, otherCount);
		if (mismatchCount + unexpectedCount + otherCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- verilog.f
rtl/CorePackage.sv
rtl/InstructionDecoder.sv
rtl/RegisterFile.sv
rtl/OperandStage.sv
rtl/ExecuteStage.sv
rtl/IntegerPipeline.sv
verification/IntegerPipelineChk.sv
verification/IntegerPipelineTb.sv
